/* sd_macros.svh */
`ifndef SD_MACROS_SVH
`define SD_MACROS_SVH

// Card clock and timing
`define SD_CLK_HALF       4     // i_clk cycles per half card clock
`define SD_PREINIT_CLKS   74    // Card clocks with CMD and DAT3 high
`define SD_WDOG_CLKS      64    // Card clocks to wait for a response start bit
`define SD_FRAME_BITS     48

// Command indices
`define SD_CMD0           6'd0
`define SD_CMD8           6'd8

// Response kinds
`define SD_RESP_NONE      2'd0
`define SD_RESP_R1        2'd1
`define SD_RESP_R7        2'd2

// Error codes
`define SD_ERR_NONE       4'd0
`define SD_ERR_TIMEOUT    4'd1
`define SD_ERR_CRC        4'd2
`define SD_ERR_BADRESP    4'd3

`endif

/* sd_pkg.sv */
`default_nettype none

package sd_pkg;

    // SD-mode response: start and direction bits lead the frame
    typedef struct packed {
        logic [1:0]  start;
        logic [5:0]  index;
        logic [31:0] arg;
    } sd_view_t;

    // SPI-mode response: R1 status byte, then the R7 payload if any
    typedef struct packed {
        logic [7:0]  r1;
        logic [31:0] arg;
    } spi_view_t;

    // One received response word, 40 bits
    typedef union packed {
        sd_view_t  sd_view;
        spi_view_t spi_view;
    } sd_resp_u;

endpackage

`default_nettype wire

/* sd_clkgen.sv */
`default_nettype none
`timescale 1ns/1ps

`include "sd_macros.svh"

module sd_clkgen (
    input  wire  i_clk,
    input  wire  i_nrst,
    output logic o_sclk,
    output logic o_sck_posedge,     // High in the first cycle of sclk high
    output logic o_sck_negedge      // High in the first cycle of sclk low
);

    localparam int CNT_W = $clog2(`SD_CLK_HALF);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`SD_CLK_HALF - 1);

    logic [CNT_W-1:0] half_cnt;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            half_cnt      <= '0;
            o_sclk        <= 1'b0;
            o_sck_posedge <= 1'b0;
            o_sck_negedge <= 1'b0;
        end else begin
            o_sck_posedge <= 1'b0;
            o_sck_negedge <= 1'b0;
            if (half_cnt == HALF_LAST) begin
                half_cnt      <= '0;
                o_sclk        <= ~o_sclk;
                o_sck_posedge <= ~o_sclk;   // Rising now
                o_sck_negedge <= o_sclk;    // Falling now
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* sd_cmd_trx.sv */
`default_nettype none
`timescale 1ns/1ps

`include "sd_macros.svh"

module sd_cmd_trx import sd_pkg::*; (
    input  wire         i_clk,
    input  wire         i_nrst,
    input  wire         i_sck_posedge,
    input  wire         i_sck_negedge,
    input  wire         i_spi_mode,
    input  wire         i_cmd_in,        // CMD in SD mode, DAT0 in SPI mode
    output logic        o_cmd,
    output logic        o_cmd_dir,       // 1 drives the line
    output logic        o_csn,
    input  wire         i_req_valid,
    input  wire  [5:0]  i_req_cmd,
    input  wire  [31:0] i_req_arg,
    input  wire  [1:0]  i_req_rn,
    output logic        o_req_ready,
    output logic        o_resp_valid,
    output sd_resp_u    o_resp_word,
    output logic [3:0]  o_resp_err
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_TX   = 2'd1;
    localparam logic [1:0] ST_WAIT = 2'd2;
    localparam logic [1:0] ST_RX   = 2'd3;

    localparam logic [5:0] CRC_START = 6'(`SD_FRAME_BITS - 8);
    localparam logic [5:0] STOP_BIT  = 6'(`SD_FRAME_BITS - 1);
    localparam logic [5:0] FRAME_END = 6'(`SD_FRAME_BITS);

    localparam int WDOG_W = $clog2(`SD_WDOG_CLKS);
    localparam logic [WDOG_W-1:0] WDOG_LAST = WDOG_W'(`SD_WDOG_CLKS - 1);

    logic [1:0]        state;
    logic [5:0]        bit_cnt;
    logic [WDOG_W-1:0] wdog;
    logic [39:0]       tx_sr;      // Start, transmission, index, argument
    logic [6:0]        crc;        // Shared by frame and response
    logic [1:0]        rn;
    logic [46:0]       rx_sr;
    logic [47:0]       rx_next;
    logic [5:0]        rx_len;
    logic              tx_bit;
    logic              accept, tx_step, tx_end;
    logic              rx_start, rx_step, rx_last, wdog_expire, finish;

    function automatic logic [6:0] crc7_next(input logic [6:0] c, input logic b);
        logic fb;
        fb = c[6] ^ b;
        return {c[5:3], c[2] ^ fb, c[1:0], fb};   // x^7 + x^3 + 1
    endfunction

    assign o_req_ready = (state == ST_IDLE);
    assign rx_next     = {rx_sr, i_cmd_in};

    assign accept      = o_req_ready & i_req_valid;
    assign tx_step     = (state == ST_TX) & i_sck_negedge & (bit_cnt != FRAME_END);
    assign tx_end      = (state == ST_TX) & i_sck_negedge & (bit_cnt == FRAME_END);
    assign rx_start    = (state == ST_WAIT) & i_sck_posedge & ~i_cmd_in;
    assign wdog_expire = (state == ST_WAIT) & i_sck_posedge & i_cmd_in & (wdog == WDOG_LAST);
    assign rx_step     = (state == ST_RX) & i_sck_posedge;
    assign rx_last     = rx_step & ((bit_cnt + 6'd1) == rx_len);
    assign finish      = rx_last | wdog_expire | (tx_end & (rn == `SD_RESP_NONE));

    always_comb begin
        if (bit_cnt < CRC_START) begin
            tx_bit = tx_sr[39];
        end else if (bit_cnt < STOP_BIT) begin
            tx_bit = crc[6];
        end else begin
            tx_bit = 1'b1;
        end
        // Response length by mode and response kind
        if (!i_spi_mode) begin
            rx_len = FRAME_END;
        end else if (rn == `SD_RESP_R1) begin
            rx_len = 6'd8;
        end else begin
            rx_len = 6'd40;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state        <= ST_IDLE;
            bit_cnt      <= '0;
            wdog         <= '0;
            o_cmd        <= 1'b1;
            o_cmd_dir    <= 1'b1;
            o_csn        <= 1'b1;
            o_resp_valid <= 1'b0;
        end else begin
            o_resp_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state   <= ST_TX;
                        bit_cnt <= '0;
                        o_csn   <= ~i_spi_mode;    // Chip select only in SPI mode
                    end
                end
                ST_TX: begin
                    if (tx_step) begin
                        o_cmd   <= tx_bit;
                        bit_cnt <= bit_cnt + 1'b1;
                    end else if (tx_end) begin
                        state     <= ST_WAIT;
                        o_cmd     <= 1'b1;
                        o_cmd_dir <= i_spi_mode;   // Release CMD for the card
                        wdog      <= '0;
                    end
                end
                ST_WAIT: begin
                    if (rx_start) begin
                        state   <= ST_RX;
                        bit_cnt <= 6'd1;           // Start bit already taken
                    end else if (i_sck_posedge) begin
                        wdog <= wdog + 1'b1;
                    end
                end
                default: begin
                    if (rx_step) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            endcase
            if (finish) begin
                state        <= ST_IDLE;
                o_resp_valid <= 1'b1;
                o_csn        <= 1'b1;
                o_cmd_dir    <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            tx_sr <= {2'b01, i_req_cmd, i_req_arg};
            rn    <= i_req_rn;
            crc   <= '0;
        end else if (tx_step) begin
            if (bit_cnt < CRC_START) begin
                tx_sr <= {tx_sr[38:0], 1'b0};
                crc   <= crc7_next(crc, tx_sr[39]);
            end else begin
                crc <= {crc[5:0], 1'b0};         // Shift the CRC out
            end
        end else if (rx_start) begin
            rx_sr <= rx_next[46:0];
            crc   <= crc7_next(7'h00, i_cmd_in);
        end else if (rx_step) begin
            rx_sr <= rx_next[46:0];
            if (bit_cnt < CRC_START) begin
                crc <= crc7_next(crc, i_cmd_in);
            end
        end

        if (rx_last) begin
            if (!i_spi_mode) begin
                o_resp_word <= rx_next[47:8];
                o_resp_err  <= (rx_next[7:1] == crc) ? `SD_ERR_NONE : `SD_ERR_CRC;
            end else if (rn == `SD_RESP_R1) begin
                o_resp_word <= {rx_next[7:0], 32'h0};
                o_resp_err  <= `SD_ERR_NONE;
            end else begin
                o_resp_word <= rx_next[39:0];
                o_resp_err  <= `SD_ERR_NONE;
            end
        end else if (wdog_expire) begin
            o_resp_err <= `SD_ERR_TIMEOUT;
        end else if (tx_end) begin
            o_resp_err <= `SD_ERR_NONE;            // No response expected
        end
    end

endmodule

`default_nettype wire

/* sd_init_seq.sv */
`default_nettype none
`timescale 1ns/1ps

`include "sd_macros.svh"

module sd_init_seq import sd_pkg::*; #(
    parameter bit SPI_MODE = 1'b0
) (
    input  wire         i_clk,
    input  wire         i_nrst,
    input  wire         i_start,
    input  wire  [3:0]  i_voltage_supply,
    input  wire  [7:0]  i_check_pattern,
    output logic        o_req_valid,
    output logic [5:0]  o_req_cmd,
    output logic [31:0] o_req_arg,
    output logic [1:0]  o_req_rn,
    input  wire         i_req_ready,
    input  wire         i_resp_valid,
    input  sd_resp_u    i_resp_word,
    input  wire  [3:0]  i_resp_err,
    output logic        o_err_valid,
    output logic [3:0]  o_err_code,
    output logic        o_done,
    output logic        o_card_v2
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_CMD0 = 2'd1;
    localparam logic [1:0] ST_CMD8 = 2'd2;
    localparam logic [1:0] ST_DONE = 2'd3;

    logic [1:0] state;
    logic [3:0] fail_code;

    // Response check for the command in flight
    always_comb begin
        fail_code = `SD_ERR_NONE;
        if (state == ST_CMD0) begin
            if (i_resp_err != `SD_ERR_NONE) begin
                fail_code = i_resp_err;
            end else if (SPI_MODE && i_resp_word.spi_view.r1 != 8'h01) begin
                fail_code = `SD_ERR_BADRESP;       // Card not in idle state
            end
        end else if (i_resp_err != `SD_ERR_TIMEOUT) begin  // Silent CMD8 is a legacy card
            if (i_resp_err != `SD_ERR_NONE) begin
                fail_code = i_resp_err;
            end else if (!SPI_MODE && i_resp_word.sd_view.index != `SD_CMD8) begin
                fail_code = `SD_ERR_BADRESP;
            end else if (i_resp_word.sd_view.arg[11:0] != o_req_arg[11:0]) begin
                fail_code = `SD_ERR_BADRESP;       // Voltage or pattern echo wrong
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state       <= ST_IDLE;
            o_req_valid <= 1'b0;
            o_req_cmd   <= '0;
            o_req_arg   <= '0;
            o_req_rn    <= `SD_RESP_NONE;
            o_err_valid <= 1'b0;
            o_err_code  <= `SD_ERR_NONE;
            o_done      <= 1'b0;
            o_card_v2   <= 1'b0;
        end else begin
            o_err_valid <= 1'b0;
            if (o_req_valid && i_req_ready) begin
                o_req_valid <= 1'b0;               // Taken by the transmitter
            end
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        state       <= ST_CMD0;
                        o_req_valid <= 1'b1;
                        o_req_cmd   <= `SD_CMD0;
                        o_req_arg   <= '0;
                        o_req_rn    <= SPI_MODE ? `SD_RESP_R1 : `SD_RESP_NONE;
                    end
                end
                ST_CMD0, ST_CMD8: begin
                    if (i_resp_valid) begin
                        if (fail_code != `SD_ERR_NONE) begin
                            state       <= ST_DONE;
                            o_err_valid <= 1'b1;
                            o_err_code  <= fail_code;
                            o_done      <= 1'b1;
                        end else if (state == ST_CMD0) begin
                            state       <= ST_CMD8;
                            o_req_valid <= 1'b1;
                            o_req_cmd   <= `SD_CMD8;
                            o_req_arg   <= {20'h0, i_voltage_supply, i_check_pattern};
                            o_req_rn    <= `SD_RESP_R7;
                        end else begin
                            state     <= ST_DONE;
                            o_done    <= 1'b1;
                            o_card_v2 <= (i_resp_err == `SD_ERR_NONE);
                        end
                    end
                end
                default: ;                         // Held until reset
            endcase
        end
    end

endmodule

`default_nettype wire

/* sd_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

`include "sd_macros.svh"

module sd_ctrl import sd_pkg::*; (
    input  wire        i_clk,
    input  wire        i_nrst,
    input  wire        i_spi_mode,        // Sampled at the end of pre-init
    input  wire  [3:0] i_voltage_supply,
    input  wire  [7:0] i_check_pattern,
    input  wire        i_err_clear,
    output logic       o_sclk,
    output logic       o_cmd,             // MOSI in SPI mode
    output logic       o_cmd_dir,         // 1 drives the line
    input  wire        i_cmd,
    input  wire        i_dat0,            // MISO in SPI mode
    output logic       o_cd_dat3,         // Chip select in SPI mode
    output logic       o_cd_dat3_dir,
    output logic       o_init_done,
    output logic       o_card_v2,
    output logic       o_err_pending,
    output logic [3:0] o_err_code
);

    localparam logic [6:0] PREINIT_LAST = 7'(`SD_PREINIT_CLKS - 1);

    logic        sck_posedge, sck_negedge;
    logic        preinit;
    logic [6:0]  preinit_cnt;
    logic        spi_mode_r;
    logic        start_r;

    logic        spi_req_valid, sd_req_valid;
    logic [5:0]  spi_req_cmd, sd_req_cmd;
    logic [31:0] spi_req_arg, sd_req_arg;
    logic [1:0]  spi_req_rn, sd_req_rn;
    logic        spi_req_ready, sd_req_ready;
    logic        spi_resp_valid, sd_resp_valid;
    logic        spi_err_valid, sd_err_valid;
    logic [3:0]  spi_err_code, sd_err_code;
    logic        spi_done, sd_done;
    logic        spi_v2, sd_v2;

    logic        trx_req_valid;
    logic [5:0]  trx_req_cmd;
    logic [31:0] trx_req_arg;
    logic [1:0]  trx_req_rn;
    logic        trx_req_ready;
    logic        trx_resp_valid;
    sd_resp_u    trx_resp_word;
    logic [3:0]  trx_resp_err;
    logic        trx_cmd, trx_cmd_dir, trx_csn;
    logic        cmd_in;
    logic        err_valid;
    logic [3:0]  err_code;

    sd_clkgen clkgen (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .o_sclk        (o_sclk),
        .o_sck_posedge (sck_posedge),
        .o_sck_negedge (sck_negedge)
    );

    // 74 card clocks of pre-init with CMD and DAT3 high, then pick the mode
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            preinit     <= 1'b1;
            preinit_cnt <= '0;
            spi_mode_r  <= 1'b0;
            start_r     <= 1'b0;
        end else begin
            start_r <= 1'b0;
            if (preinit && sck_posedge) begin
                if (preinit_cnt == PREINIT_LAST) begin
                    preinit    <= 1'b0;
                    spi_mode_r <= i_spi_mode;
                    start_r    <= 1'b1;
                end else begin
                    preinit_cnt <= preinit_cnt + 1'b1;
                end
            end
        end
    end

    sd_init_seq #(.SPI_MODE(1'b1)) spi_seq (
        .i_clk            (i_clk),
        .i_nrst           (i_nrst),
        .i_start          (start_r & spi_mode_r),
        .i_voltage_supply (i_voltage_supply),
        .i_check_pattern  (i_check_pattern),
        .o_req_valid      (spi_req_valid),
        .o_req_cmd        (spi_req_cmd),
        .o_req_arg        (spi_req_arg),
        .o_req_rn         (spi_req_rn),
        .i_req_ready      (spi_req_ready),
        .i_resp_valid     (spi_resp_valid),
        .i_resp_word      (trx_resp_word),
        .i_resp_err       (trx_resp_err),
        .o_err_valid      (spi_err_valid),
        .o_err_code       (spi_err_code),
        .o_done           (spi_done),
        .o_card_v2        (spi_v2)
    );

    sd_init_seq #(.SPI_MODE(1'b0)) sd_seq (
        .i_clk            (i_clk),
        .i_nrst           (i_nrst),
        .i_start          (start_r & ~spi_mode_r),
        .i_voltage_supply (i_voltage_supply),
        .i_check_pattern  (i_check_pattern),
        .o_req_valid      (sd_req_valid),
        .o_req_cmd        (sd_req_cmd),
        .o_req_arg        (sd_req_arg),
        .o_req_rn         (sd_req_rn),
        .i_req_ready      (sd_req_ready),
        .i_resp_valid     (sd_resp_valid),
        .i_resp_word      (trx_resp_word),
        .i_resp_err       (trx_resp_err),
        .o_err_valid      (sd_err_valid),
        .o_err_code       (sd_err_code),
        .o_done           (sd_done),
        .o_card_v2        (sd_v2)
    );

    // Fixed grant by mode
    assign trx_req_valid  = spi_mode_r ? spi_req_valid : sd_req_valid;
    assign trx_req_cmd    = spi_mode_r ? spi_req_cmd   : sd_req_cmd;
    assign trx_req_arg    = spi_mode_r ? spi_req_arg   : sd_req_arg;
    assign trx_req_rn     = spi_mode_r ? spi_req_rn    : sd_req_rn;
    assign spi_req_ready  = spi_mode_r & trx_req_ready;
    assign sd_req_ready   = ~spi_mode_r & trx_req_ready;
    assign spi_resp_valid = spi_mode_r & trx_resp_valid;
    assign sd_resp_valid  = ~spi_mode_r & trx_resp_valid;
    assign err_valid      = spi_mode_r ? spi_err_valid : sd_err_valid;
    assign err_code       = spi_mode_r ? spi_err_code  : sd_err_code;
    assign o_init_done    = spi_mode_r ? spi_done      : sd_done;
    assign o_card_v2      = spi_mode_r ? spi_v2        : sd_v2;

    sd_cmd_trx cmd_trx (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_sck_posedge (sck_posedge),
        .i_sck_negedge (sck_negedge),
        .i_spi_mode    (spi_mode_r),
        .i_cmd_in      (cmd_in),
        .o_cmd         (trx_cmd),
        .o_cmd_dir     (trx_cmd_dir),
        .o_csn         (trx_csn),
        .i_req_valid   (trx_req_valid),
        .i_req_cmd     (trx_req_cmd),
        .i_req_arg     (trx_req_arg),
        .i_req_rn      (trx_req_rn),
        .o_req_ready   (trx_req_ready),
        .o_resp_valid  (trx_resp_valid),
        .o_resp_word   (trx_resp_word),
        .o_resp_err    (trx_resp_err)
    );

    // The idle transmitter holds CMD and CSn high through pre-init
    assign cmd_in        = spi_mode_r ? i_dat0 : i_cmd;
    assign o_cmd         = trx_cmd;
    assign o_cmd_dir     = trx_cmd_dir;
    assign o_cd_dat3     = trx_csn;
    assign o_cd_dat3_dir = preinit | spi_mode_r;   // Input in SD mode

    // Sticky error register keeps the first code
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_err_pending <= 1'b0;
            o_err_code    <= `SD_ERR_NONE;
        end else if (i_err_clear) begin
            o_err_pending <= 1'b0;
            o_err_code    <= `SD_ERR_NONE;
        end else if (err_valid && !o_err_pending) begin
            o_err_pending <= 1'b1;
            o_err_code    <= err_code;
        end
    end

endmodule

`default_nettype wire

/* tb_sd_card.sv */
`default_nettype none
`timescale 1ns/1ps

`include "sd_macros.svh"

module tb_sd_card (
    input  wire         i_sclk,
    input  wire         i_spi_mode,
    input  wire         i_cmd,          // Host CMD, MOSI in SPI mode
    input  wire         i_csn,          // DAT3, chip select in SPI mode
    input  wire         i_present,
    input  wire         i_answer_cmd8,
    input  wire         i_bad_echo,
    input  wire         i_bad_crc,
    output logic        o_cmd,          // Card side of CMD, high when idle
    output logic        o_dat0,         // MISO in SPI mode
    output logic [47:0] o_frame,
    output logic [15:0] o_frame_cnt,
    output logic [15:0] o_crc_errs
);

    logic [47:0] frame;
    logic [31:0] echo;
    logic [39:0] word;

    // CRC7 with polynomial x^7 + x^3 + 1, MSB first
    function automatic logic [6:0] crc7(input logic [39:0] d);
        logic [6:0] c;
        logic       fb;
        c = 7'h00;
        for (int i = 39; i >= 0; i--) begin
            fb = c[6] ^ d[i];
            c  = {c[5:0], 1'b0} ^ {3'b000, fb, 2'b00, fb};
        end
        return c;
    endfunction

    // Collects 48 bits from the first 0 on the host line
    task automatic get_frame(output logic [47:0] f);
        int n;
        n = 0;
        f = '0;
        while (n < 48) begin
            @(posedge i_sclk);
            if (i_spi_mode && i_csn) begin
                n = 0;                      // Deselected, drop partial frame
            end else if (n > 0 || !i_cmd) begin
                f = {f[46:0], i_cmd};
                n = n + 1;
            end
        end
    endtask

    task automatic reply(input logic [47:0] bits, input int n);
        repeat (4) @(negedge i_sclk);       // Response gap
        for (int i = n - 1; i >= 0; i--) begin
            @(negedge i_sclk);
            if (i_spi_mode) begin
                o_dat0 <= bits[i];
            end else begin
                o_cmd <= bits[i];
            end
        end
        @(negedge i_sclk);
        o_cmd  <= 1'b1;
        o_dat0 <= 1'b1;
    endtask

    initial begin
        o_cmd       <= 1'b1;
        o_dat0      <= 1'b1;
        o_frame     <= '0;
        o_frame_cnt <= '0;
        o_crc_errs  <= '0;
        forever begin
            get_frame(frame);
            o_frame     <= frame;
            o_frame_cnt <= o_frame_cnt + 16'd1;
            if (frame[7:1] != crc7(frame[47:8]) || !frame[0]) begin
                o_crc_errs <= o_crc_errs + 16'd1;
            end
            echo = {20'h0, frame[19:8]};    // Voltage and check pattern
            if (i_bad_echo) begin
                echo[7:0] = ~echo[7:0];
            end
            if (i_present && frame[45:40] == `SD_CMD0 && i_spi_mode) begin
                reply(48'h01, 8);           // R1, idle state
            end else if (i_present && frame[45:40] == `SD_CMD8 && i_answer_cmd8) begin
                if (i_spi_mode) begin
                    reply({8'h00, 8'h01, echo}, 40);
                end else begin
                    word = {2'b00, `SD_CMD8, echo};
                    reply({word, crc7(word) ^ {6'd0, i_bad_crc}, 1'b1}, 48);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_sd_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

`include "sd_macros.svh"

module tb_sd_ctrl;

    localparam int SCENARIOS = 6;
    localparam int SCK_NS    = 2 * `SD_CLK_HALF * 10;
    // Pre-init plus two commands per scenario and twice that as margin
    localparam int LIMIT_NS  = 2 * SCENARIOS * (`SD_PREINIT_CLKS + 2 * 160) * SCK_NS;

    logic        clk = 1'b0;
    logic        nrst;
    logic        spi_mode;
    logic [3:0]  voltage_supply;
    logic [7:0]  check_pattern;
    logic        err_clear;
    logic        sclk;
    logic        cmd;
    logic        cmd_dir;
    logic        cd_dat3;
    logic        cd_dat3_dir;
    logic        init_done;
    logic        card_v2;
    logic        err_pending;
    logic [3:0]  err_code;
    logic        card_cmd;
    logic        card_dat0;
    logic [47:0] card_frame;
    logic [15:0] card_frame_cnt;
    logic [15:0] card_crc_errs;
    logic        card_spi;
    logic        card_present;
    logic        card_answer8;
    logic        card_bad_echo;
    logic        card_bad_crc;

    logic [31:0] lcg_state;
    logic [47:0] exp_frames[$];
    logic [47:0] exp_frame;
    logic [15:0] frames_seen    = '0;
    logic        sclk_q         = 1'b0;
    logic        first_low_seen = 1'b0;
    int          sclk_rises     = 0;
    int          errors         = 0;
    int          checks         = 0;

    sd_ctrl DUT (
        .i_clk            (clk),
        .i_nrst           (nrst),
        .i_spi_mode       (spi_mode),
        .i_voltage_supply (voltage_supply),
        .i_check_pattern  (check_pattern),
        .i_err_clear      (err_clear),
        .o_sclk           (sclk),
        .o_cmd            (cmd),
        .o_cmd_dir        (cmd_dir),
        .i_cmd            (card_cmd),
        .i_dat0           (card_dat0),
        .o_cd_dat3        (cd_dat3),
        .o_cd_dat3_dir    (cd_dat3_dir),
        .o_init_done      (init_done),
        .o_card_v2        (card_v2),
        .o_err_pending    (err_pending),
        .o_err_code       (err_code)
    );

    tb_sd_card card (
        .i_sclk        (sclk),
        .i_spi_mode    (card_spi),
        .i_cmd         (cmd),
        .i_csn         (cd_dat3),
        .i_present     (card_present),
        .i_answer_cmd8 (card_answer8),
        .i_bad_echo    (card_bad_echo),
        .i_bad_crc     (card_bad_crc),
        .o_cmd         (card_cmd),
        .o_dat0        (card_dat0),
        .o_frame       (card_frame),
        .o_frame_cnt   (card_frame_cnt),
        .o_crc_errs    (card_crc_errs)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected command frame with start, host bit, index, argument, CRC7 and stop
    function automatic logic [47:0] frame_ref(input logic [5:0] idx, input logic [31:0] arg);
        logic [39:0] head;
        logic [6:0]  c;
        head = {2'b01, idx, arg};
        c    = 7'h00;
        for (int i = 39; i >= 0; i--) begin
            c = (c[6] ^ head[i]) ? ({c[5:0], 1'b0} ^ 7'h09) : {c[5:0], 1'b0};
        end
        return {head, c, 1'b1};
    endfunction

    task automatic check_value(input string name, input logic [47:0] actual,
                               input logic [47:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("Error: %s = %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    // CMD and DAT3 driven high for 74 card clocks before the first 0 on CMD
    always @(posedge clk) begin
        sclk_q <= sclk;
        if (!nrst) begin
            sclk_rises     <= 0;
            first_low_seen <= 1'b0;
        end else if (!first_low_seen && sclk && !sclk_q) begin
            if (!cmd) begin
                first_low_seen <= 1'b1;
                checks++;
                if (sclk_rises < `SD_PREINIT_CLKS) begin
                    $display("First CMD start bit after only %0d card clocks", sclk_rises);
                    errors++;
                end
            end else begin
                sclk_rises <= sclk_rises + 1;
                if (sclk_rises < `SD_PREINIT_CLKS) begin
                    check_value("o_cd_dat3", cd_dat3, 1'b1);
                    check_value("o_cmd_dir", cmd_dir, 1'b1);
                    check_value("o_cd_dat3_dir", cd_dat3_dir, 1'b1);
                end
            end
        end
    end

    // Each frame seen by the card against the queue of expected frames
    always @(posedge clk) begin
        if (card_frame_cnt != frames_seen) begin
            frames_seen <= card_frame_cnt;
            if (exp_frames.size() == 0) begin
                $display("Unexpected command frame %h from the host", card_frame);
                errors++;
            end else begin
                exp_frame = exp_frames.pop_front();
                check_value("frame", card_frame, exp_frame);
            end
        end
    end

    // The host must release CMD while the card drives a response bit
    always @(posedge clk) begin
        if (nrst && !card_spi && !card_cmd && cmd_dir) begin
            $display("Error: o_cmd_dir = %h, expected 0 while the card drives CMD", cmd_dir);
            errors++;
        end
    end

    task automatic run_scenario(input logic spi, input logic answer8, input logic bad_echo,
                                input logic bad_crc, input logic present,
                                input logic exp_v2, input logic [3:0] exp_err);
        logic [31:0] arg;
        lcg_state = lcg_next(lcg_state);
        arg       = {20'h0, 4'h1, lcg_state[23:16]};
        exp_frames.push_back(frame_ref(`SD_CMD0, 32'h0));
        if (!spi || present) begin
            exp_frames.push_back(frame_ref(`SD_CMD8, arg));   // CMD0 passes
        end
        @(posedge clk);
        nrst           <= 1'b0;
        spi_mode       <= spi;
        voltage_supply <= arg[11:8];
        check_pattern  <= arg[7:0];
        card_spi       <= spi;
        card_present   <= present;
        card_answer8   <= answer8;
        card_bad_echo  <= bad_echo;
        card_bad_crc   <= bad_crc;
        repeat (2) @(posedge clk);
        nrst <= 1'b1;
        @(posedge clk);
        while (!init_done) begin
            @(posedge clk);
        end
        @(posedge clk);                     // Error register latches
        check_value("o_card_v2", card_v2, exp_v2);
        check_value("o_err_pending", err_pending, exp_err != `SD_ERR_NONE);
        check_value("o_err_code", err_code, exp_err);
        check_value("o_cmd_dir", cmd_dir, 1'b1);
        check_value("o_cd_dat3_dir", cd_dat3_dir, spi);
        if (exp_frames.size() != 0) begin
            $display("%0d expected command frames never appeared", exp_frames.size());
            errors++;
            exp_frames.delete();
        end
    endtask

    initial begin
        nrst           <= 1'b0;
        spi_mode       <= 1'b0;
        voltage_supply <= 4'h0;
        check_pattern  <= 8'h00;
        err_clear      <= 1'b0;
        card_spi       <= 1'b0;
        card_present   <= 1'b0;
        card_answer8   <= 1'b0;
        card_bad_echo  <= 1'b0;
        card_bad_crc   <= 1'b0;
        lcg_state = 32'h2db6_ba6b;

        run_scenario(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, `SD_ERR_NONE);     // SD v2
        run_scenario(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, `SD_ERR_NONE);     // SPI v2
        run_scenario(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, `SD_ERR_NONE);     // Legacy
        run_scenario(1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, `SD_ERR_CRC);
        run_scenario(1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, `SD_ERR_BADRESP);
        run_scenario(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, `SD_ERR_TIMEOUT);  // Empty slot

        @(posedge clk);
        err_clear <= 1'b1;
        @(posedge clk);
        err_clear <= 1'b0;
        @(posedge clk);
        check_value("o_err_pending", err_pending, 1'b0);
        check_value("o_err_code", err_code, `SD_ERR_NONE);

        if (card_crc_errs != 0) begin
            $display("Card model received %0d frames with a bad CRC7", card_crc_errs);
            errors += card_crc_errs;
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(LIMIT_NS);
        $display("Timeout: the init sequences did not finish within %0d ns", LIMIT_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
sd_pkg.sv
sd_clkgen.sv
sd_cmd_trx.sv
sd_init_seq.sv
sd_ctrl.sv
tb_sd_card.sv
tb_sd_ctrl.sv

/* Makefile */
SRC := $(filter %.sv,$(shell cat list.f))

.PHONY: run clean

obj_dir/Vtb_sd_ctrl: $(SRC) sd_macros.svh list.f
	verilator --binary --timing -Wno-fatal --top-module tb_sd_ctrl -f list.f

run: obj_dir/Vtb_sd_ctrl
	obj_dir/Vtb_sd_ctrl | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
